/* hw/cx4_pkg.sv */
package cx4_pkg;

  //////////////////////////////
  // basic widths
  //////////////////////////////
  typedef logic [7:0]  byte_t;
  typedef logic [12:0] host_addr_t;
  typedef logic [23:0] bus_addr_t;
  typedef logic [11:0] dat_addr_t;
  typedef logic [9:0]  pgm_addr_t;  // msb is the cache page
  typedef logic [14:0] page_t;
  typedef logic [15:0] dma_len_t;   // 0 means 65536

  //////////////////////////////
  // host address map
  //////////////////////////////
  localparam host_addr_t DATRAM_LIMIT = 13'h0c00;  // 3 KB data ram
  localparam host_addr_t PGM_WIN_BASE = 13'h1c00;  // 512 byte cache window
  localparam host_addr_t MMIO_BASE    = 13'h1f40;
  localparam host_addr_t STATUS_BASE  = 13'h1f53;

  // register offsets inside the mmio window
  localparam logic [4:0] REG_DMASRC0   = 5'h00;
  localparam logic [4:0] REG_DMASRC1   = 5'h01;
  localparam logic [4:0] REG_DMASRC2   = 5'h02;
  localparam logic [4:0] REG_DMALEN0   = 5'h03;
  localparam logic [4:0] REG_DMALEN1   = 5'h04;
  localparam logic [4:0] REG_DMATGT0   = 5'h05;
  localparam logic [4:0] REG_DMATGT1   = 5'h06;
  localparam logic [4:0] REG_DMATGT2   = 5'h07;  // write starts dma
  localparam logic [4:0] REG_CACHEPAGE = 5'h08;  // write starts cache fill
  localparam logic [4:0] REG_PGMOFF0   = 5'h09;
  localparam logic [4:0] REG_PGMOFF1   = 5'h0a;
  localparam logic [4:0] REG_PGMOFF2   = 5'h0b;
  localparam logic [4:0] REG_PGMPAGE0  = 5'h0d;
  localparam logic [4:0] REG_PGMPAGE1  = 5'h0e;

  //////////////////////////////
  // transfer and strobe timing
  //////////////////////////////
  localparam dma_len_t CACHE_PAGE_BYTES = 16'd512;
  localparam int       WR_LOW_CYCLES    = 5;  // nWR low samples before release

endpackage

/* hw/cx4_dp_ram.sv */
`timescale 1ns/1ps

module cx4_dp_ram import cx4_pkg::*; #(
  parameter int ADDR_W = 12
) (
  input  logic              CLK,
  input  logic              a_we,
  input  logic [ADDR_W-1:0] a_addr,
  input  byte_t             a_din,
  input  logic              b_we,
  input  logic [ADDR_W-1:0] b_addr,
  input  byte_t             b_din,
  output byte_t             a_dout
);

  byte_t mem [2**ADDR_W];

  // port a is the host side, port b the engine fill side
  always_ff @(posedge CLK) begin
    if (a_we) begin
      mem[a_addr] <= a_din;
    end
    if (b_we) begin
      mem[b_addr] <= b_din;  // engines never write where the host is
    end
    a_dout <= mem[a_addr];   // registered read
  end

endmodule

/* hw/cx4_host_regs.sv */
`timescale 1ns/1ps

module cx4_host_regs import cx4_pkg::*; (
  input  logic       CLK,
  input  logic       arst_n,
  input  host_addr_t ADDR,
  input  byte_t      DI,
  input  logic       CS,
  input  logic       nWR,
  input  byte_t      dat_rdata,
  input  byte_t      pgm_rdata,
  input  logic       active,
  output byte_t      DO,
  output logic       dat_we,
  output bus_addr_t  dma_src,
  output dma_len_t   dma_len,
  output dat_addr_t  dma_tgt,
  output logic       cache_page,
  output bus_addr_t  pgm_off,
  output page_t      pgm_page,
  output logic       dma_go,
  output logic       cache_go
);

  typedef enum logic [1:0] {RD_REG, RD_DAT, RD_PGM} rd_src_t;

  logic [WR_LOW_CYCLES:0] nwr_hist;
  logic                   wr_strobe;
  logic                   in_window;
  logic                   dat_sel;
  logic                   pgm_sel;
  logic                   mmio_sel;
  logic                   stat_sel;
  logic                   reg_we;
  logic [23:0]            dmatgt_q;
  byte_t                  reg_rdata;
  byte_t                  reg_rd_q;
  rd_src_t                rd_src_q;

  //////////////////////////////
  // write strobe
  //////////////////////////////
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      nwr_hist <= '1;
    end else begin
      nwr_hist <= {nwr_hist[WR_LOW_CYCLES-1:0], nWR};
    end
  end

  // release of nWR after enough low samples
  assign wr_strobe = (nwr_hist == {{WR_LOW_CYCLES{1'b0}}, 1'b1});

  //////////////////////////////
  // address decode
  //////////////////////////////
  assign in_window = (ADDR[12:5] == MMIO_BASE[12:5]);
  assign dat_sel   = CS && (ADDR < DATRAM_LIMIT);
  assign pgm_sel   = CS && (ADDR[12:9] == PGM_WIN_BASE[12:9]);
  assign mmio_sel  = CS && in_window && (ADDR[4:0] < STATUS_BASE[4:0]);
  assign stat_sel  = CS && in_window && (ADDR[4:0] >= STATUS_BASE[4:0]);

  assign dat_we = dat_sel && wr_strobe;
  assign reg_we = mmio_sel && wr_strobe;

  //////////////////////////////
  // mmio registers
  //////////////////////////////
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      dma_src    <= '0;
      dma_len    <= '0;
      dmatgt_q   <= '0;
      cache_page <= 1'b0;
      pgm_off    <= '0;
      pgm_page   <= '0;
      dma_go     <= 1'b0;
      cache_go   <= 1'b0;
    end else begin
      dma_go   <= reg_we && (ADDR[4:0] == REG_DMATGT2);    // one cycle pulse
      cache_go <= reg_we && (ADDR[4:0] == REG_CACHEPAGE);
      if (reg_we) begin
        case (ADDR[4:0])
          REG_DMASRC0:   dma_src[7:0]    <= DI;
          REG_DMASRC1:   dma_src[15:8]   <= DI;
          REG_DMASRC2:   dma_src[23:16]  <= DI;
          REG_DMALEN0:   dma_len[7:0]    <= DI;
          REG_DMALEN1:   dma_len[15:8]   <= DI;
          REG_DMATGT0:   dmatgt_q[7:0]   <= DI;
          REG_DMATGT1:   dmatgt_q[15:8]  <= DI;
          REG_DMATGT2:   dmatgt_q[23:16] <= DI;
          REG_CACHEPAGE: cache_page      <= DI[0];
          REG_PGMOFF0:   pgm_off[7:0]    <= DI;
          REG_PGMOFF1:   pgm_off[15:8]   <= DI;
          REG_PGMOFF2:   pgm_off[23:16]  <= DI;
          REG_PGMPAGE0:  pgm_page[7:0]   <= DI;
          REG_PGMPAGE1:  pgm_page[14:8]  <= DI[6:0];
          default: ;                                       // dropped registers
        endcase
      end
    end
  end

  assign dma_tgt = dmatgt_q[11:0];  // data ram is only 3 KB

  //////////////////////////////
  // read path
  //////////////////////////////
  always_comb begin
    reg_rdata = 8'hff;
    if (stat_sel) begin
      reg_rdata = {1'b0, active, 4'b0000, ~active, 1'b0};
    end else if (mmio_sel) begin
      case (ADDR[4:0])
        REG_DMASRC0:   reg_rdata = dma_src[7:0];
        REG_DMASRC1:   reg_rdata = dma_src[15:8];
        REG_DMASRC2:   reg_rdata = dma_src[23:16];
        REG_DMALEN0:   reg_rdata = dma_len[7:0];
        REG_DMALEN1:   reg_rdata = dma_len[15:8];
        REG_DMATGT0:   reg_rdata = dmatgt_q[7:0];
        REG_DMATGT1:   reg_rdata = dmatgt_q[15:8];
        REG_DMATGT2:   reg_rdata = dmatgt_q[23:16];
        REG_CACHEPAGE: reg_rdata = {7'b0, cache_page};
        REG_PGMOFF0:   reg_rdata = pgm_off[7:0];
        REG_PGMOFF1:   reg_rdata = pgm_off[15:8];
        REG_PGMOFF2:   reg_rdata = pgm_off[23:16];
        REG_PGMPAGE0:  reg_rdata = pgm_page[7:0];
        REG_PGMPAGE1:  reg_rdata = {1'b0, pgm_page[14:8]};
        default:       reg_rdata = 8'hff;
      endcase
    end
  end

  // stage one lines up with the ram read
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rd_src_q <= RD_REG;
    end else if (dat_sel) begin
      rd_src_q <= RD_DAT;
    end else if (pgm_sel) begin
      rd_src_q <= RD_PGM;
    end else begin
      rd_src_q <= RD_REG;
    end
  end

  always_ff @(posedge CLK) begin
    reg_rd_q <= reg_rdata;
    case (rd_src_q)          // stage two drives DO
      RD_DAT:  DO <= dat_rdata;
      RD_PGM:  DO <= pgm_rdata;
      default: DO <= reg_rd_q;
    endcase
  end

  // 1f47 and 1f48 are separate host writes, so triggers never coincide
  a_trig_excl: assert property (@(posedge CLK) disable iff (!arst_n)
    !(dma_go && cache_go))
    else $error("dma_go and cache_go pulsed together");

endmodule

/* hw/cx4_bus_fetch.sv */
`timescale 1ns/1ps

module cx4_bus_fetch import cx4_pkg::*; #(
  parameter type tgt_addr_t = dat_addr_t
) (
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      start,
  input  bus_addr_t src,
  input  tgt_addr_t tgt,
  input  dma_len_t  count,
  input  logic      grant,
  input  logic      fetch_rdy,
  output logic      fetch_rrq,
  output bus_addr_t fetch_addr,
  output logic      wr_en,
  output tgt_addr_t wr_addr,
  output logic      busy,
  output logic      done
);

  typedef enum logic [4:0] {
    ST_IDLE    = 5'b00001,
    ST_START   = 5'b00010,
    ST_WAIT    = 5'b00100,
    ST_ADVANCE = 5'b01000,
    ST_END     = 5'b10000
  } state_t;

  state_t    state;
  bus_addr_t src_q;
  tgt_addr_t tgt_q;
  dma_len_t  left_q;
  logic      got_byte;

  // rdy in the request cycle belongs to nobody
  assign got_byte = (state == ST_WAIT) && !fetch_rrq && fetch_rdy;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ST_IDLE;
      fetch_rrq <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          if (grant) begin       // wait here while the other engine owns the bus
            fetch_rrq <= 1'b1;
            state     <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          fetch_rrq <= 1'b0;
          if (got_byte) begin
            state <= ST_ADVANCE;
          end
        end
        ST_ADVANCE: begin
          if (left_q == '0) begin
            state <= ST_END;
          end else begin
            fetch_rrq <= 1'b1;   // next byte
            state     <= ST_WAIT;
          end
        end
        default: state <= ST_IDLE;  // ST_END
      endcase
    end
  end

  // addresses and byte counter
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && start) begin
      src_q  <= src;
      tgt_q  <= tgt;
      left_q <= count;           // zero wraps to 65536 bytes
    end
    if (got_byte) begin
      left_q <= left_q - 1'b1;
    end
    if (state == ST_ADVANCE) begin
      src_q <= src_q + 1'b1;
      tgt_q <= tgt_q + 1'b1;
    end
  end

  // bit 15 of the logical address is not on the cart bus
  assign fetch_addr = {1'b0, src_q[23:16], src_q[14:0]};
  assign wr_en      = got_byte;
  assign wr_addr    = tgt_q;
  assign busy       = (state != ST_IDLE);
  assign done       = (state == ST_END);

  a_rrq_single: assert property (@(posedge CLK) disable iff (!arst_n)
    fetch_rrq |=> !fetch_rrq)
    else $error("fetch_rrq held for more than one cycle");

endmodule

/* hw/cx4_cache_ctrl.sv */
`timescale 1ns/1ps

module cx4_cache_ctrl import cx4_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      cache_go,
  input  logic      cache_page,
  input  bus_addr_t pgm_off,
  input  page_t     pgm_page,
  input  logic      grant,
  input  logic      fetch_rdy,
  output logic      fetch_rrq,
  output bus_addr_t fetch_addr,
  output logic      pgm_we,
  output pgm_addr_t pgm_waddr,
  output logic      busy,
  output logic      done
);

  logic [1:0] tag_valid;
  page_t      tag_page [2];
  logic       fill_half;
  page_t      fill_page;
  logic       hit;
  logic       fill_start;
  bus_addr_t  fill_src;
  pgm_addr_t  fill_tgt;

  assign hit        = tag_valid[cache_page] && (tag_page[cache_page] == pgm_page);
  assign fill_start = cache_go && !hit && !busy;
  assign fill_src   = pgm_off + {pgm_page, 9'h000};  // 512 bytes per page
  assign fill_tgt   = {cache_page, 9'h000};

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tag_valid <= 2'b00;
    end else if (fill_start) begin
      tag_valid[cache_page] <= 1'b0;  // half is stale while it fills
    end else if (done) begin
      tag_valid[fill_half] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (fill_start) begin
      fill_half <= cache_page;
      fill_page <= pgm_page;
    end
    if (done) begin
      tag_page[fill_half] <= fill_page;
    end
  end

  cx4_bus_fetch #(
    .tgt_addr_t (pgm_addr_t)
  ) fill_fetch_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .start      (fill_start),
    .src        (fill_src),
    .tgt        (fill_tgt),
    .count      (CACHE_PAGE_BYTES),
    .grant      (grant),
    .fetch_rdy  (fetch_rdy),
    .fetch_rrq  (fetch_rrq),
    .fetch_addr (fetch_addr),
    .wr_en      (pgm_we),
    .wr_addr    (pgm_waddr),
    .busy       (busy),
    .done       (done)
  );

endmodule

/* hw/cx4_bus_arb.sv */
`timescale 1ns/1ps

module cx4_bus_arb import cx4_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      cache_busy,
  input  logic      cache_rrq,
  input  bus_addr_t cache_addr,
  input  logic      cache_done,
  input  logic      dma_busy,
  input  logic      dma_rrq,
  input  bus_addr_t dma_addr,
  input  logic      dma_done,
  input  logic      BUS_RDY,
  output logic      cache_grant,
  output logic      dma_grant,
  output logic      cache_rdy,
  output logic      dma_rdy,
  output logic      BUS_RRQ,
  output bus_addr_t BUS_ADDR,
  output logic      active
);

  typedef enum logic [1:0] {OWN_NONE, OWN_CACHE, OWN_DMA} owner_t;

  owner_t owner;

  // grant at idle right away, cache wins a tie
  assign cache_grant = (owner == OWN_CACHE) || (owner == OWN_NONE && cache_busy);
  assign dma_grant   = (owner == OWN_DMA) ||
                       (owner == OWN_NONE && dma_busy && !cache_busy);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      owner <= OWN_NONE;
    end else begin
      case (owner)
        OWN_NONE: begin
          if (cache_busy) begin
            owner <= OWN_CACHE;
          end else if (dma_busy) begin
            owner <= OWN_DMA;
          end
        end
        OWN_CACHE: if (cache_done) owner <= OWN_NONE;
        OWN_DMA:   if (dma_done) owner <= OWN_NONE;
        default:   owner <= OWN_NONE;
      endcase
    end
  end

  assign BUS_RRQ   = (cache_grant && cache_rrq) || (dma_grant && dma_rrq);
  assign BUS_ADDR  = dma_grant ? dma_addr : cache_addr;
  assign cache_rdy = cache_grant && BUS_RDY;  // loser never sees rdy
  assign dma_rdy   = dma_grant && BUS_RDY;
  assign active    = cache_busy || dma_busy;

  a_grant_excl: assert property (@(posedge CLK) disable iff (!arst_n)
    !(cache_grant && dma_grant))
    else $error("both engines granted the bus");

endmodule

/* hw/cx4_top.sv */
`timescale 1ns/1ps

module cx4_top import cx4_pkg::*; (
  input  logic       CLK,
  input  logic       arst_n,
  input  host_addr_t ADDR,
  input  byte_t      DI,
  input  logic       CS,
  input  logic       nRD,      // pin compatible, reads decode on CS and ADDR
  input  logic       nWR,
  input  byte_t      BUS_DI,
  input  logic       BUS_RDY,
  output byte_t      DO,
  output bus_addr_t  BUS_ADDR,
  output logic       BUS_RRQ,
  output logic       cx4_active
);

  byte_t     dat_rdata;
  byte_t     pgm_rdata;
  logic      dat_we;
  bus_addr_t dma_src;
  dma_len_t  dma_len;
  dat_addr_t dma_tgt;
  logic      cache_page;
  bus_addr_t pgm_off;
  page_t     pgm_page;
  logic      dma_go;
  logic      cache_go;

  logic      cache_rrq, cache_busy, cache_done, cache_grant, cache_rdy;
  bus_addr_t cache_addr;
  logic      pgm_we;
  pgm_addr_t pgm_waddr;

  logic      dma_rrq, dma_busy, dma_done, dma_grant, dma_rdy;
  bus_addr_t dma_addr;
  logic      dma_we;
  dat_addr_t dma_waddr;

  //////////////////////////////
  // host side
  //////////////////////////////
  cx4_host_regs host_regs_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .ADDR       (ADDR),
    .DI         (DI),
    .CS         (CS),
    .nWR        (nWR),
    .dat_rdata  (dat_rdata),
    .pgm_rdata  (pgm_rdata),
    .active     (cx4_active),
    .DO         (DO),
    .dat_we     (dat_we),
    .dma_src    (dma_src),
    .dma_len    (dma_len),
    .dma_tgt    (dma_tgt),
    .cache_page (cache_page),
    .pgm_off    (pgm_off),
    .pgm_page   (pgm_page),
    .dma_go     (dma_go),
    .cache_go   (cache_go)
  );

  //////////////////////////////
  // transfer engines
  //////////////////////////////
  cx4_cache_ctrl cache_ctrl_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .cache_go   (cache_go),
    .cache_page (cache_page),
    .pgm_off    (pgm_off),
    .pgm_page   (pgm_page),
    .grant      (cache_grant),
    .fetch_rdy  (cache_rdy),
    .fetch_rrq  (cache_rrq),
    .fetch_addr (cache_addr),
    .pgm_we     (pgm_we),
    .pgm_waddr  (pgm_waddr),
    .busy       (cache_busy),
    .done       (cache_done)
  );

  cx4_bus_fetch #(
    .tgt_addr_t (dat_addr_t)
  ) dma_fetch_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .start      (dma_go),
    .src        (dma_src),
    .tgt        (dma_tgt),
    .count      (dma_len),
    .grant      (dma_grant),
    .fetch_rdy  (dma_rdy),
    .fetch_rrq  (dma_rrq),
    .fetch_addr (dma_addr),
    .wr_en      (dma_we),
    .wr_addr    (dma_waddr),
    .busy       (dma_busy),
    .done       (dma_done)
  );

  cx4_bus_arb bus_arb_i (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .cache_busy  (cache_busy),
    .cache_rrq   (cache_rrq),
    .cache_addr  (cache_addr),
    .cache_done  (cache_done),
    .dma_busy    (dma_busy),
    .dma_rrq     (dma_rrq),
    .dma_addr    (dma_addr),
    .dma_done    (dma_done),
    .BUS_RDY     (BUS_RDY),
    .cache_grant (cache_grant),
    .dma_grant   (dma_grant),
    .cache_rdy   (cache_rdy),
    .dma_rdy     (dma_rdy),
    .BUS_RRQ     (BUS_RRQ),
    .BUS_ADDR    (BUS_ADDR),
    .active      (cx4_active)
  );

  //////////////////////////////
  // memories
  //////////////////////////////
  cx4_dp_ram #(
    .ADDR_W ($bits(dat_addr_t))
  ) dat_ram_i (
    .CLK    (CLK),
    .a_we   (dat_we),
    .a_addr (ADDR[11:0]),
    .a_din  (DI),
    .b_we   (dma_we),
    .b_addr (dma_waddr),
    .b_din  (BUS_DI),
    .a_dout (dat_rdata)
  );

  // host only reads the selected half through the window
  cx4_dp_ram #(
    .ADDR_W ($bits(pgm_addr_t))
  ) pgm_ram_i (
    .CLK    (CLK),
    .a_we   (1'b0),
    .a_addr ({cache_page, ADDR[8:0]}),
    .a_din  (DI),
    .b_we   (pgm_we),
    .b_addr (pgm_waddr),
    .b_din  (BUS_DI),
    .a_dout (pgm_rdata)
  );

endmodule

/* bench/cx4_tb.sv */
`timescale 1ns/1ps

module cx4_tb import cx4_pkg::*; ();

  localparam int MAX_CYCLES = 20000;  // two fills and two dmas at 6 cycles a byte, plus host

  logic       CLK;
  logic       arst_n;
  host_addr_t ADDR;
  byte_t      DI;
  logic       CS;
  logic       nRD;
  logic       nWR;
  byte_t      BUS_DI;
  logic       BUS_RDY;
  byte_t      DO;
  bus_addr_t  BUS_ADDR;
  logic       BUS_RRQ;
  logic       cx4_active;

  integer     seed = 32'h8e35895e;
  bus_addr_t  exp_addrs [2048];  // every expected bus address in order
  int         exp_count  = 0;
  int         xfer_first = 0;    // index of the first request of the running test
  int         rrq_idx    = 0;    // requests seen by the bus model
  int         rdy_cnt    = 0;    // bytes delivered by the bus model
  int         cycle_cnt  = 0;

  cx4_top dut_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .ADDR       (ADDR),
    .DI         (DI),
    .CS         (CS),
    .nRD        (nRD),
    .nWR        (nWR),
    .BUS_DI     (BUS_DI),
    .BUS_RDY    (BUS_RDY),
    .DO         (DO),
    .BUS_ADDR   (BUS_ADDR),
    .BUS_RRQ    (BUS_RRQ),
    .cx4_active (cx4_active)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  //////////////////////////////
  // failure handling
  //////////////////////////////
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "first error ends the run");
  endtask

  task automatic report_mismatch(input string msg);
    stop_with_failure($sformatf("CHECK FAILED at %0t: %s", $time, msg));
  endtask

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      stop_with_failure($sformatf("run timed out after %0d clock cycles", MAX_CYCLES));
    end
  end

  //////////////////////////////
  // bus checks
  //////////////////////////////
  a_reset_quiet: assert property (@(posedge CLK) (!arst_n && $past(!arst_n)) |->
    (!BUS_RRQ && !cx4_active))
    else report_mismatch("BUS_RRQ or cx4_active high during reset");

  a_no_extra_rrq: assert property (@(posedge CLK) disable iff (!arst_n)
    BUS_RRQ |-> (rrq_idx < exp_count))
    else report_mismatch("BUS_RRQ with no request expected");

  a_rrq_addr: assert property (@(posedge CLK) disable iff (!arst_n)
    BUS_RRQ |-> (BUS_ADDR == exp_addrs[rrq_idx]))
    else report_mismatch($sformatf("BUS_ADDR %h, expected %h", BUS_ADDR, exp_addrs[rrq_idx]));

  a_active_held: assert property (@(posedge CLK) disable iff (!arst_n)
    (rrq_idx > xfer_first && rdy_cnt < exp_count) |-> cx4_active)
    else report_mismatch("cx4_active low before the last byte arrived");

  // cartridge model answering each request after 1 to 4 cycles
  initial begin : bus_model
    bus_addr_t req_addr;
    int        delay;
    BUS_RDY = 1'b0;
    BUS_DI  = '0;
    forever begin
      @(negedge CLK);
      if (BUS_RRQ) begin
        req_addr = BUS_ADDR;
        delay    = 1 + ($random(seed) & 3);
        @(posedge CLK);
        rrq_idx <= rrq_idx + 1;
        repeat (delay - 1) @(posedge CLK);
        BUS_RDY <= 1'b1;
        BUS_DI  <= model_byte(req_addr);
        @(posedge CLK);
        BUS_RDY <= 1'b0;
        rdy_cnt <= rdy_cnt + 1;
      end
    end
  end

  //////////////////////////////
  // reference rules
  //////////////////////////////
  function automatic bus_addr_t map_addr(input bus_addr_t a);
    return {1'b0, a[23:16], a[14:0]};  // bit 15 is not on the cart bus
  endfunction

  function automatic byte_t model_byte(input bus_addr_t a);
    return a[7:0] ^ a[15:8];
  endfunction

  function automatic bus_addr_t fill_source(input bus_addr_t off, input page_t page);
    return off + bus_addr_t'(page) * 512;
  endfunction

  function automatic byte_t ram_pattern(input dat_addr_t a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
  endfunction

  function automatic byte_t reg_pattern(input logic [4:0] off);
    return {1'b0, off[3:0], off[2:0]} ^ 8'h25;  // bit 7 clear for pgmpage1
  endfunction

  //////////////////////////////
  // host port
  //////////////////////////////
  task automatic host_write(input host_addr_t a, input byte_t d);
    @(posedge CLK);
    ADDR <= a;
    DI   <= d;
    CS   <= 1'b1;
    nWR  <= 1'b0;
    repeat (6) @(posedge CLK);
    nWR <= 1'b1;            // taken on release
    repeat (2) @(posedge CLK);
    CS  <= 1'b0;
  endtask

  task automatic host_read(input host_addr_t a, output byte_t d);
    @(posedge CLK);
    ADDR <= a;
    CS   <= 1'b1;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    d = DO;
  endtask

  task automatic expect_read(input host_addr_t a, input byte_t exp, input string what);
    byte_t got;
    host_read(a, got);
    assert (got == exp)
      else report_mismatch($sformatf("%s, read %h at %h, expected %h", what, got, a, exp));
  endtask

  //////////////////////////////
  // transfer helpers
  //////////////////////////////
  task automatic mark_transfer();
    @(negedge CLK);
    xfer_first = exp_count;
  endtask

  task automatic queue_fetch(input bus_addr_t src, input int n);
    @(negedge CLK);
    for (int i = 0; i < n; i++) begin
      exp_addrs[exp_count] = map_addr(src + bus_addr_t'(i));
      exp_count++;
    end
  endtask

  task automatic wait_transfer_done();
    @(negedge CLK);
    while (!cx4_active) begin
      @(negedge CLK);
    end
    while (cx4_active) begin
      @(negedge CLK);
    end
    assert (rrq_idx == exp_count && rdy_cnt == exp_count)
      else report_mismatch($sformatf("%0d requests and %0d bytes, expected %0d",
                                     rrq_idx, rdy_cnt, exp_count));
  endtask

  task automatic load_dma_regs(input bus_addr_t src, input dma_len_t len, input dat_addr_t tgt);
    host_write(MMIO_BASE + REG_DMASRC0, src[7:0]);
    host_write(MMIO_BASE + REG_DMASRC1, src[15:8]);
    host_write(MMIO_BASE + REG_DMASRC2, src[23:16]);
    host_write(MMIO_BASE + REG_DMALEN0, len[7:0]);
    host_write(MMIO_BASE + REG_DMALEN1, len[15:8]);
    host_write(MMIO_BASE + REG_DMATGT0, tgt[7:0]);
    host_write(MMIO_BASE + REG_DMATGT1, {4'h0, tgt[11:8]});
  endtask

  task automatic load_pgm_regs(input bus_addr_t off, input page_t page);
    host_write(MMIO_BASE + REG_PGMOFF0, off[7:0]);
    host_write(MMIO_BASE + REG_PGMOFF1, off[15:8]);
    host_write(MMIO_BASE + REG_PGMOFF2, off[23:16]);
    host_write(MMIO_BASE + REG_PGMPAGE0, page[7:0]);
    host_write(MMIO_BASE + REG_PGMPAGE1, {1'b0, page[14:8]});
  endtask

  task automatic check_dma_data(input bus_addr_t src, input dat_addr_t tgt, input int n);
    for (int i = 0; i < n; i++) begin
      expect_read({1'b0, tgt + dat_addr_t'(i)}, model_byte(map_addr(src + bus_addr_t'(i))),
                  "dma data");
    end
  endtask

  task automatic check_window(input bus_addr_t src);
    for (int i = 0; i < 512; i++) begin
      expect_read(PGM_WIN_BASE + host_addr_t'(i), model_byte(map_addr(src + bus_addr_t'(i))),
                  "cache window");
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic check_registers();
    logic [4:0] kept [12];
    logic [4:0] dropped [5];
    kept    = '{REG_DMASRC0, REG_DMASRC1, REG_DMASRC2, REG_DMALEN0, REG_DMALEN1,
                REG_DMATGT0, REG_DMATGT1, REG_PGMOFF0, REG_PGMOFF1, REG_PGMOFF2,
                REG_PGMPAGE0, REG_PGMPAGE1};
    dropped = '{5'h0c, 5'h0f, 5'h10, 5'h11, 5'h12};
    foreach (kept[i]) begin
      host_write(MMIO_BASE + kept[i], reg_pattern(kept[i]));
    end
    foreach (kept[i]) begin
      expect_read(MMIO_BASE + kept[i], reg_pattern(kept[i]), "register readback");
    end
    foreach (dropped[i]) begin
      expect_read(MMIO_BASE + dropped[i], 8'hff, "dropped register");
    end
  endtask

  task automatic check_data_ram();
    dat_addr_t spots [6];
    spots = '{12'h000, 12'h0a5, 12'h3ff, 12'h400, 12'h7c3, 12'hbff};
    foreach (spots[i]) begin
      host_write({1'b0, spots[i]}, ram_pattern(spots[i]));
    end
    foreach (spots[i]) begin
      expect_read({1'b0, spots[i]}, ram_pattern(spots[i]), "data ram readback");
    end
  endtask

  task automatic run_dma_test();
    mark_transfer();
    queue_fetch(24'h03fff0, 40);          // crosses a bank and has bit 15 set
    load_dma_regs(24'h03fff0, 16'd40, 12'h3f0);
    host_write(MMIO_BASE + REG_DMATGT2, 8'h5a);
    wait_transfer_done();
    expect_read(MMIO_BASE + REG_DMATGT2, 8'h5a, "dma target high byte");
    expect_read(STATUS_BASE, 8'h02, "status after dma");
    check_dma_data(24'h03fff0, 12'h3f0, 40);
  endtask

  task automatic run_cache_test();
    load_pgm_regs(24'h028100, 15'd3);
    mark_transfer();
    queue_fetch(fill_source(24'h028100, 15'd3), 512);
    host_write(MMIO_BASE + REG_CACHEPAGE, 8'h01);
    expect_read(STATUS_BASE, 8'h40, "status during cache fill");
    wait_transfer_done();
    expect_read(MMIO_BASE + REG_CACHEPAGE, 8'h01, "cache page register");
    check_window(fill_source(24'h028100, 15'd3));
    // same page and half again has to hit
    mark_transfer();
    host_write(MMIO_BASE + REG_CACHEPAGE, 8'h01);
    repeat (50) begin
      @(negedge CLK);
      assert (!cx4_active) else report_mismatch("cx4_active rose on a cache hit");
    end
  endtask

  task automatic run_overlap_test();
    load_pgm_regs(24'h028100, 15'd5);
    load_dma_regs(24'h7f7fe8, 16'd40, 12'h800);
    mark_transfer();
    queue_fetch(fill_source(24'h028100, 15'd5), 512);
    queue_fetch(24'h7f7fe8, 40);          // dma must wait for the whole fill
    host_write(MMIO_BASE + REG_CACHEPAGE, 8'h00);
    while (rrq_idx < xfer_first + 8) begin
      @(negedge CLK);
    end
    host_write(MMIO_BASE + REG_DMATGT2, 8'h00);
    wait_transfer_done();
    check_window(fill_source(24'h028100, 15'd5));
    check_dma_data(24'h7f7fe8, 12'h800, 40);
  endtask

  initial begin
    arst_n = 1'b0;
    ADDR   = '0;
    DI     = '0;
    CS     = 1'b0;
    nRD    = 1'b1;
    nWR    = 1'b1;
    repeat (5) @(posedge CLK);
    arst_n <= 1'b1;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    assert (!BUS_RRQ && !cx4_active) else report_mismatch("bus not idle after reset");
    expect_read(STATUS_BASE, 8'h02, "status after reset");
    check_registers();
    check_data_ram();
    run_dma_test();
    run_cache_test();
    run_overlap_test();
    $display("Regression passed");
    $finish;
  end

endmodule

/* compile.f */
hw/cx4_pkg.sv
hw/cx4_dp_ram.sv
hw/cx4_host_regs.sv
hw/cx4_bus_fetch.sv
hw/cx4_cache_ctrl.sv
hw/cx4_bus_arb.sv
hw/cx4_top.sv
bench/cx4_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then decide from the simulation log
verilator --binary --assert -Wno-fatal --top-module cx4_tb -f compile.f -o cx4_sim \
  > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/cx4_sim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
